//--- rtl/afifo_pkg.sv
package afifo_pkg;

   // write side carries words, read side returns bytes
   localparam int W_DATA_W  = 32;
   localparam int R_DATA_W  = 8;

   // bytes per word and its log
   localparam int RATIO     = W_DATA_W / R_DATA_W;
   localparam int RATIO_LOG = $clog2(RATIO);

   // byte address width sets the capacity
   localparam int ADDR_W    = 5;

   // word address width of the storage array
   localparam int W_ADDR_W  = ADDR_W - RATIO_LOG;

   localparam int FIFO_BYTES = 1 << ADDR_W;

   // one write word
   typedef logic [W_DATA_W-1:0] w_data_t;

   // one read byte
   typedef logic [R_DATA_W-1:0] r_data_t;

   // fill level in bytes, one extra bit so a full FIFO reads as FIFO_BYTES
   typedef logic [ADDR_W:0] level_t;

endpackage

//--- rtl/gray_counter.sv
`timescale 1ns/1ps

module gray_counter #(
   parameter int PTR_W = 4
) (
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic             en_i,
   output logic [PTR_W-1:0] bin_o,
   output logic [PTR_W-1:0] gray_o
);

   logic [PTR_W-1:0] bin_q;
   logic [PTR_W-1:0] gray_q;
   logic [PTR_W-1:0] bin_nxt;

   assign bin_nxt = bin_q + PTR_W'(1);

   // the gray copy is a flop of its own, never a decode of bin_q,
   // so the bus seen by the other clock domain changes one bit at a time
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bin_q  <= '0;
         gray_q <= '0;
      end else if (en_i) begin
         bin_q  <= bin_nxt;
         gray_q <= bin_nxt ^ (bin_nxt >> 1);
      end
   end

   assign bin_o  = bin_q;
   assign gray_o = gray_q;

endmodule

//--- rtl/ptr_sync.sv
`timescale 1ns/1ps

module ptr_sync #(
   parameter int PTR_W = 4
) (
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic [PTR_W-1:0] gray_i,
   output logic [PTR_W-1:0] bin_o
);

   // first stage may go metastable, only the second one is used
   logic [PTR_W-1:0] gray_meta_q;
   logic [PTR_W-1:0] gray_sync_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gray_meta_q <= '0;
         gray_sync_q <= '0;
      end else begin
         gray_meta_q <= gray_i;
         gray_sync_q <= gray_meta_q;
      end
   end

   // gray to binary
   // each binary bit is the xor of all gray bits at or above it
   always_comb begin
      for (int i = 0; i < PTR_W; i++) begin
         bin_o[i] = ^(gray_sync_q >> i);
      end
   end

endmodule

//--- rtl/fifo_ptr_ctrl.sv
`timescale 1ns/1ps

module fifo_ptr_ctrl #(
   parameter int PTR_W = 4,
   // log2 of the bytes moved per access in this domain
   parameter int SHIFT = 2
) (
   input  logic                                                   clk_i,
   input  logic                                                   arst_n_i,
   input  logic                                                   en_i,
   input  logic [afifo_pkg::ADDR_W-afifo_pkg::RATIO_LOG+SHIFT:0] other_bin_i,
   output logic [PTR_W-1:0]                                       bin_o,
   output logic [PTR_W-1:0]                                       gray_o,
   output afifo_pkg::level_t                                      level_o,
   output logic                                                   empty_o,
   output logic                                                   full_o,
   output logic                                                   acc_o
);

   import afifo_pkg::*;

   // the other domain's pointer counts the other unit
   localparam int OTHER_SHIFT = RATIO_LOG - SHIFT;

   // a word domain gates on full, a byte domain gates on empty
   localparam bit IS_WRITE = (SHIFT > 0);

   // bytes moved by one access here
   localparam level_t STEP = level_t'(1) << SHIFT;

   localparam level_t FULL_AT = level_t'(FIFO_BYTES) - STEP;

   level_t own_bytes;
   level_t other_bytes;

   gray_counter #(
      .PTR_W(PTR_W)
   ) u_cnt (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .en_i    (acc_o),
      .bin_o   (bin_o),
      .gray_o  (gray_o)
   );

   // both pointers in bytes
   assign own_bytes   = level_t'(bin_o) << SHIFT;
   assign other_bytes = level_t'(other_bin_i) << OTHER_SHIFT;

   // modulo subtraction, the wrap bit keeps full and empty apart
   assign level_o = IS_WRITE ? (own_bytes - other_bytes) : (other_bytes - own_bytes);

   // empty means less than one access worth of data is left
   assign empty_o = (level_o < STEP);

   // full means one more access would not fit
   assign full_o  = (level_o > FULL_AT);

   assign acc_o = en_i & ~(IS_WRITE ? full_o : empty_o);

endmodule

//--- rtl/lane_ram.sv
`timescale 1ns/1ps

module lane_ram (
   // write side
   input  logic                             w_clk_i,
   input  logic                             w_we_i,
   input  logic [afifo_pkg::W_ADDR_W-1:0]   w_addr_i,
   input  afifo_pkg::w_data_t               w_lanes_i,
   // read side
   input  logic                             r_clk_i,
   input  logic                             r_re_i,
   input  logic [afifo_pkg::W_ADDR_W-1:0]   r_addr_i,
   output afifo_pkg::w_data_t               r_lanes_o
);

   import afifo_pkg::*;

   // one narrow array per byte lane, all sharing the word address
   for (genvar l = 0; l < RATIO; l++) begin : g_lane

      r_data_t mem [1 << W_ADDR_W];
      r_data_t rd_q;

      // whole word goes in at once, every lane on the same edge
      always_ff @(posedge w_clk_i) begin
         if (w_we_i) begin
            mem[w_addr_i] <= w_lanes_i[l*R_DATA_W +: R_DATA_W];
         end
      end

      // read port holds its last value between pops
      always_ff @(posedge r_clk_i) begin
         if (r_re_i) begin
            rd_q <= mem[r_addr_i];
         end
      end

      assign r_lanes_o[l*R_DATA_W +: R_DATA_W] = rd_q;

   end

endmodule

//--- rtl/asym_width_converter.sv
`timescale 1ns/1ps

module asym_width_converter (
   input  logic                           w_clk_i,
   input  logic                           r_clk_i,
   input  logic                           arst_n_i,
   // write domain
   input  logic                           w_acc_i,
   input  logic [afifo_pkg::W_ADDR_W-1:0] w_addr_i,
   input  afifo_pkg::w_data_t             w_data_i,
   // read domain
   input  logic                           r_acc_i,
   input  logic [afifo_pkg::ADDR_W-1:0]   r_addr_i,
   input  afifo_pkg::w_data_t             r_lanes_i,
   // storage side
   output logic                           mem_we_o,
   output logic [afifo_pkg::W_ADDR_W-1:0] mem_waddr_o,
   output afifo_pkg::w_data_t             mem_wdata_o,
   output logic                           mem_re_o,
   output logic [afifo_pkg::W_ADDR_W-1:0] mem_raddr_o,
   output afifo_pkg::r_data_t             r_data_o
);

   import afifo_pkg::*;

   w_data_t                w_lanes;
   w_data_t                w_hold_q;
   logic [RATIO_LOG-1:0]   lane_sel_q;
   logic                   popped_q;

   // byte 0 of the word lands in lane 0, so it is read out first
   always_comb begin
      for (int l = 0; l < RATIO; l++) begin
         w_lanes[l*R_DATA_W +: R_DATA_W] = w_data_i[l*R_DATA_W +: R_DATA_W];
      end
   end

   // keep the storage write bus still between accepted words
   always_ff @(posedge w_clk_i) begin
      if (w_acc_i) begin
         w_hold_q <= w_lanes;
      end
   end

   assign mem_we_o    = w_acc_i;
   assign mem_waddr_o = w_addr_i;
   assign mem_wdata_o = w_acc_i ? w_lanes : w_hold_q;

   // upper byte address bits pick the word
   assign mem_re_o    = r_acc_i;
   assign mem_raddr_o = r_addr_i[ADDR_W-1:RATIO_LOG];

   // lane select follows the word read, both taken on the popping edge
   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lane_sel_q <= '0;
         popped_q   <= 1'b0;
      end else if (r_acc_i) begin
         lane_sel_q <= r_addr_i[RATIO_LOG-1:0];
         popped_q   <= 1'b1;
      end
   end

   // storage output is unknown until the first pop
   assign r_data_o = popped_q ? r_lanes_i[lane_sel_q*R_DATA_W +: R_DATA_W] : '0;

endmodule

//--- rtl/afifo_async.sv
`timescale 1ns/1ps

module afifo_async (
   input  logic                 w_clk_i,
   input  logic                 r_clk_i,
   input  logic                 arst_n_i,
   // write port
   input  logic                 w_en_i,
   input  afifo_pkg::w_data_t   w_data_i,
   output logic                 w_full_o,
   output logic                 w_empty_o,
   output afifo_pkg::level_t    w_level_o,
   // read port
   input  logic                 r_en_i,
   output afifo_pkg::r_data_t   r_data_o,
   output logic                 r_empty_o,
   output logic                 r_full_o,
   output afifo_pkg::level_t    r_level_o
);

   import afifo_pkg::*;

   // write pointer counts words, read pointer counts bytes
   localparam int W_PTR_W = W_ADDR_W + 1;
   localparam int R_PTR_W = ADDR_W + 1;

   logic [W_PTR_W-1:0]  w_bin;
   logic [W_PTR_W-1:0]  w_gray;
   logic [W_PTR_W-1:0]  r_wbin;
   logic [R_PTR_W-1:0]  r_bin;
   logic [R_PTR_W-1:0]  r_gray;
   logic [R_PTR_W-1:0]  w_rbin;
   logic                w_acc;
   logic                r_acc;

   logic                mem_we;
   logic [W_ADDR_W-1:0] mem_waddr;
   w_data_t             mem_wdata;
   logic                mem_re;
   logic [W_ADDR_W-1:0] mem_raddr;
   w_data_t             mem_rlanes;

   // write domain
   fifo_ptr_ctrl #(
      .PTR_W(W_PTR_W),
      .SHIFT(RATIO_LOG)
   ) w_ctrl (
      .clk_i      (w_clk_i),
      .arst_n_i   (arst_n_i),
      .en_i       (w_en_i),
      .other_bin_i(w_rbin),
      .bin_o      (w_bin),
      .gray_o     (w_gray),
      .level_o    (w_level_o),
      .empty_o    (w_empty_o),
      .full_o     (w_full_o),
      .acc_o      (w_acc)
   );

   // read domain
   fifo_ptr_ctrl #(
      .PTR_W(R_PTR_W),
      .SHIFT(0)
   ) r_ctrl (
      .clk_i      (r_clk_i),
      .arst_n_i   (arst_n_i),
      .en_i       (r_en_i),
      .other_bin_i(r_wbin),
      .bin_o      (r_bin),
      .gray_o     (r_gray),
      .level_o    (r_level_o),
      .empty_o    (r_empty_o),
      .full_o     (r_full_o),
      .acc_o      (r_acc)
   );

   // write pointer into the read clock
   ptr_sync #(
      .PTR_W(W_PTR_W)
   ) w2r_sync (
      .clk_i   (r_clk_i),
      .arst_n_i(arst_n_i),
      .gray_i  (w_gray),
      .bin_o   (r_wbin)
   );

   // read pointer into the write clock
   ptr_sync #(
      .PTR_W(R_PTR_W)
   ) r2w_sync (
      .clk_i   (w_clk_i),
      .arst_n_i(arst_n_i),
      .gray_i  (r_gray),
      .bin_o   (w_rbin)
   );

   asym_width_converter u_conv (
      .w_clk_i    (w_clk_i),
      .r_clk_i    (r_clk_i),
      .arst_n_i   (arst_n_i),
      .w_acc_i    (w_acc),
      .w_addr_i   (w_bin[W_ADDR_W-1:0]),
      .w_data_i   (w_data_i),
      .r_acc_i    (r_acc),
      .r_addr_i   (r_bin[ADDR_W-1:0]),
      .r_lanes_i  (mem_rlanes),
      .mem_we_o   (mem_we),
      .mem_waddr_o(mem_waddr),
      .mem_wdata_o(mem_wdata),
      .mem_re_o   (mem_re),
      .mem_raddr_o(mem_raddr),
      .r_data_o   (r_data_o)
   );

   lane_ram u_ram (
      .w_clk_i  (w_clk_i),
      .w_we_i   (mem_we),
      .w_addr_i (mem_waddr),
      .w_lanes_i(mem_wdata),
      .r_clk_i  (r_clk_i),
      .r_re_i   (mem_re),
      .r_addr_i (mem_raddr),
      .r_lanes_o(mem_rlanes)
   );

endmodule

//--- verif/afifo_props.sv
`timescale 1ns/1ps

module afifo_props (
   input logic              w_clk_i,
   input logic              r_clk_i,
   input logic              arst_n_i,
   input logic              w_en_i,
   input logic              w_full_i,
   input logic              w_empty_i,
   input afifo_pkg::level_t w_level_i,
   input logic              r_en_i,
   input logic              r_empty_i,
   input afifo_pkg::level_t r_level_i
);

   import afifo_pkg::*;

   // read by the testbench to stop the run
   int err_cnt = 0;

   // a word needs RATIO free bytes
   assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      w_full_i == (w_level_i > (FIFO_BYTES - RATIO)))
   else begin
      $error("w_full_o does not follow w_level_o");
      err_cnt++;
   end
   assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      w_empty_i == (w_level_i < RATIO))
   else begin
      $error("w_empty_o does not follow w_level_o");
      err_cnt++;
   end
   assert property (@(posedge r_clk_i) disable iff (!arst_n_i)
      r_empty_i == (r_level_i == 0))
   else begin
      $error("r_empty_o does not follow r_level_o");
      err_cnt++;
   end
   assert property (@(posedge w_clk_i) disable iff (!arst_n_i) w_level_i <= FIFO_BYTES)
   else begin
      $error("w_level_o above the FIFO capacity");
      err_cnt++;
   end
   assert property (@(posedge r_clk_i) disable iff (!arst_n_i) r_level_i <= FIFO_BYTES)
   else begin
      $error("r_level_o above the FIFO capacity");
      err_cnt++;
   end
   // only a pop can lower the read level
   assert property (@(posedge r_clk_i) disable iff (!arst_n_i)
      !(r_en_i && !r_empty_i) |=> (r_level_i >= $past(r_level_i)))
   else begin
      $error("r_level_o fell without a pop");
      err_cnt++;
   end
   // only a write can raise the write level
   assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      !(w_en_i && !w_full_i) |=> (w_level_i <= $past(w_level_i)))
   else begin
      $error("w_level_o rose without a write");
      err_cnt++;
   end

endmodule

bind afifo_async afifo_props u_props (
   .w_clk_i  (w_clk_i),
   .r_clk_i  (r_clk_i),
   .arst_n_i (arst_n_i),
   .w_en_i   (w_en_i),
   .w_full_i (w_full_o),
   .w_empty_i(w_empty_o),
   .w_level_i(w_level_o),
   .r_en_i   (r_en_i),
   .r_empty_i(r_empty_o),
   .r_level_i(r_level_o)
);

//--- verif/afifo_tb.sv
`timescale 1ns/1ps

module afifo_tb;

   import afifo_pkg::*;

   logic        w_clk;
   logic        r_clk;
   logic        arst_n;
   logic        w_en;
   w_data_t     w_data;
   logic        w_full;
   logic        w_empty;
   level_t      w_level;
   logic        r_en;
   r_data_t     r_data;
   logic        r_empty;
   logic        r_full;
   level_t      r_level;

   // bytes in flight, lane 0 of each word first
   r_data_t     sb_q[$];
   r_data_t     exp_byte;
   logic        check_due = 1'b0;
   logic [31:0] lcg_state;
   int          words_done;
   logic        writes_done;
   r_data_t     held;

   afifo_async UUT (
      .w_clk_i  (w_clk),
      .r_clk_i  (r_clk),
      .arst_n_i (arst_n),
      .w_en_i   (w_en),
      .w_data_i (w_data),
      .w_full_o (w_full),
      .w_empty_o(w_empty),
      .w_level_o(w_level),
      .r_en_i   (r_en),
      .r_data_o (r_data),
      .r_empty_o(r_empty),
      .r_full_o (r_full),
      .r_level_o(r_level)
   );

   initial begin
      w_clk = 1'b0;
      forever #4 w_clk = ~w_clk;
   end

   // read clock lags the write clock by 3 ns
   initial begin
      r_clk = 1'b0;
      #3;
      forever #4 r_clk = ~r_clk;
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic stop_failed();
      $display("Checks failed");
      $fatal(1, "stopping at the first failed check");
   endtask

   task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
      assert (act === exp)
      else begin
         $display("mismatch %s expected 0x%h actual 0x%h", name, exp, act);
         stop_failed();
      end
   endtask

   task automatic write_word(input w_data_t d);
      @(posedge w_clk);
      while (w_full) @(posedge w_clk);
      w_en   <= 1'b1;
      w_data <= d;
      @(posedge w_clk);
      w_en   <= 1'b0;
   endtask

   task automatic read_byte();
      @(posedge r_clk);
      while (r_empty) @(posedge r_clk);
      r_en <= 1'b1;
      @(posedge r_clk);
      r_en <= 1'b0;
   endtask

   // every accepted word enters the scoreboard as four bytes
   always @(posedge w_clk) begin
      if (arst_n && w_en && !w_full) begin
         for (int b = 0; b < RATIO; b++) begin
            sb_q.push_back(w_data[b*R_DATA_W +: R_DATA_W]);
         end
      end
   end

   // a popped byte is on r_data one edge after the pop
   always @(posedge r_clk) begin
      if (check_due) begin
         assert (r_data === exp_byte)
         else begin
            $display("mismatch r_data_o expected 0x%h actual 0x%h", exp_byte, r_data);
            stop_failed();
         end
      end
      check_due = 1'b0;
      if (arst_n && r_en && !r_empty) begin
         if (sb_q.size() == 0) begin
            $display("a byte was popped that was never written");
            stop_failed();
         end else begin
            exp_byte  = sb_q.pop_front();
            check_due = 1'b1;
         end
      end
   end

   initial begin
      wait (UUT.u_props.err_cnt != 0);
      $display("a flag or level property of the FIFO failed");
      stop_failed();
   end

   // 400 words of 4 bytes at up to 6 cycles of 8 ns each, plus 2 us
   initial begin
      #(400 * 4 * 6 * 8 + 2000);
      $display("run timed out before the tests finished");
      stop_failed();
   end

   initial begin
      lcg_state   = 32'd9;
      arst_n      = 1'b0;
      w_en        = 1'b0;
      w_data      = '0;
      r_en        = 1'b0;
      words_done  = 0;
      writes_done = 1'b0;
      repeat (10) @(posedge w_clk);
      arst_n <= 1'b1;
      @(posedge w_clk);
      check_eq("r_empty_o", r_empty, 1);
      check_eq("w_empty_o", w_empty, 1);
      check_eq("w_full_o", w_full, 0);
      check_eq("r_full_o", r_full, 0);
      check_eq("w_level_o", w_level, 0);
      check_eq("r_level_o", r_level, 0);
      check_eq("r_data_o", r_data, 0);

      // byte order through the width converter
      write_word(32'h44332211);
      write_word(32'h88776655);
      repeat (8) read_byte();

      // let the read pointer reach the write side before filling
      while (w_level != 0) @(posedge w_clk);
      for (int i = 0; i < 8; i++) begin
         write_word(next_random());
      end
      @(posedge w_clk);
      check_eq("w_full_o", w_full, 1);
      check_eq("w_level_o", w_level, FIFO_BYTES);
      w_en   <= 1'b1;
      w_data <= next_random();
      repeat (5) begin
         @(posedge w_clk);
         check_eq("w_level_o", w_level, FIFO_BYTES);
      end
      w_en <= 1'b0;

      // read side fills up once the write pointer has crossed
      while (!r_full) @(posedge r_clk);
      check_eq("r_level_o", r_level, FIFO_BYTES);

      // drain, then pop from an empty FIFO
      repeat (FIFO_BYTES) read_byte();
      @(posedge r_clk);
      check_eq("r_empty_o", r_empty, 1);
      check_eq("r_level_o", r_level, 0);
      held = r_data;
      r_en <= 1'b1;
      repeat (5) begin
         @(posedge r_clk);
         check_eq("r_level_o", r_level, 0);
         check_eq("r_data_o", r_data, held);
      end
      r_en <= 1'b0;
      while (!w_empty) @(posedge w_clk);
      check_eq("w_level_o", w_level, 0);

      // random traffic on both sides
      fork
         begin
            while (words_done < 400) begin
               @(posedge w_clk);
               if (w_en && !w_full) begin
                  words_done++;
               end
               w_en   <= (words_done < 400) && (next_random() > 32'h3fffffff);
               w_data <= next_random();
            end
            writes_done = 1'b1;
         end
         begin
            // stop once both domains see the FIFO drained
            while (!(writes_done && w_level == 0 && r_empty)) begin
               @(posedge r_clk);
               r_en <= (next_random() > 32'h3fffffff);
            end
            r_en <= 1'b0;
         end
      join

      repeat (4) @(posedge r_clk);
      if (sb_q.size() != 0) begin
         $display("scoreboard still holds %0d bytes at the end", sb_q.size());
         stop_failed();
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

//--- verilog.f
rtl/afifo_pkg.sv
rtl/gray_counter.sv
rtl/ptr_sync.sv
rtl/fifo_ptr_ctrl.sv
rtl/lane_ram.sv
rtl/asym_width_converter.sv
rtl/afifo_async.sv
verif/afifo_props.sv
verif/afifo_tb.sv
